// File: design/cache_pkg.sv
`default_nettype none

package cache_pkg;

    //////////////////////////////
    // Basic widths
    //////////////////////////////

    typedef logic [31:0] word_t;
    typedef logic [29:0] word_addr_t;
    typedef logic [3:0]  byte_en_t;

    // Manager FSM
    typedef enum logic [2:0] {
        NORMAL,
        IC_MISS,
        DC_MISS,
        DOUBLE_MISS,
        DC_WRITEBACK
    } mgr_state_e;

    // Source of the RAM word address
    typedef enum logic [1:0] {
        IC_LINE,
        DC_LINE,
        DC_VICTIM
    } ram_sel_e;

    //////////////////////////////
    // Bundles
    //////////////////////////////

    typedef struct packed {
        logic       read;
        logic       write;
        word_addr_t addr;
        word_t      wdata;
        byte_en_t   byte_en;
    } dc_req_t;

    typedef struct packed {
        logic     enable;
        logic     cmp;
        logic     write;
        logic     valid_in;
        byte_en_t byte_en;
    } set_cmd_t;

    typedef struct packed {
        logic hit;
        logic valid;
        logic dirty;
    } set_status_t;

    typedef struct packed {
        logic       en;
        logic       write;
        word_addr_t addr;
        word_t      wdata;
    } ram_req_t;

endpackage

`default_nettype wire

// File: design/cache_set_array.sv
`timescale 1ns/100ps
`default_nettype none

module cache_set_array #(
    parameter int OFFSET_WIDTH = 3,
    parameter int INDEX_WIDTH  = 6,
    localparam int TAG_WIDTH   = 30 - OFFSET_WIDTH - INDEX_WIDTH
) (
    input  logic                    clk,
    input  logic                    rst,
    input  cache_pkg::set_cmd_t     cmd,
    input  logic [INDEX_WIDTH-1:0]  index,
    input  logic [OFFSET_WIDTH-1:0] word_sel,
    input  logic [TAG_WIDTH-1:0]    tag_in,
    input  cache_pkg::word_t        wdata,
    output cache_pkg::set_status_t  status,
    output logic [TAG_WIDTH-1:0]    tag_out,
    output cache_pkg::word_t        rdata
);

    localparam int SETS       = 1 << INDEX_WIDTH;
    localparam int LINE_WORDS = 1 << OFFSET_WIDTH;

    typedef logic [TAG_WIDTH-1:0]                tag_t;
    typedef logic [INDEX_WIDTH+OFFSET_WIDTH-1:0] word_index_t;

    // Storage, way index first
    tag_t             tag_mem  [2][SETS];
    cache_pkg::word_t data_mem [2][SETS*LINE_WORDS];
    logic [SETS-1:0]  valid_q  [2];
    logic [SETS-1:0]  dirty_q  [2];
    logic [SETS-1:0]  lru_q;

    logic [1:0]       way_hit;
    logic             hit_any;
    logic             victim_way;
    logic             sel_way;
    word_index_t      word_index;
    cache_pkg::word_t merged_word;
    logic             fill;
    logic             store;
    logic             touch;

    assign word_index = {index, word_sel};

    //////////////////////////////
    // Lookup
    //////////////////////////////

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_hit[w] = valid_q[w][index] && (tag_mem[w][index] == tag_in);
        end
    end

    assign hit_any = |way_hit;

    // Empty ways go first, then the LRU bit decides
    always_comb begin
        if (!valid_q[0][index]) begin
            victim_way = 1'b0;
        end else if (!valid_q[1][index]) begin
            victim_way = 1'b1;
        end else begin
            victim_way = lru_q[index];
        end
    end

    // Compare hit picks the hit way, anything else the victim
    assign sel_way = (cmd.cmp && hit_any) ? way_hit[1] : victim_way;

    assign status.hit   = cmd.enable & cmd.cmp & hit_any;
    assign status.valid = valid_q[sel_way][index];
    assign status.dirty = valid_q[sel_way][index] & dirty_q[sel_way][index];

    assign tag_out = tag_mem[sel_way][index];
    assign rdata   = data_mem[sel_way][word_index];

    // Byte merge of the new word into the stored one
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            merged_word[8*b +: 8] = cmd.byte_en[b] ? wdata[8*b +: 8] : rdata[8*b +: 8];
        end
    end

    //////////////////////////////
    // Updates
    //////////////////////////////

    assign fill  = cmd.enable & ~cmd.cmp & cmd.write;
    assign store = cmd.enable & cmd.cmp & cmd.write & hit_any;
    assign touch = cmd.enable & cmd.cmp & hit_any;

    always_ff @(posedge clk) begin
        if (fill || store) begin
            data_mem[sel_way][word_index] <= merged_word;
        end
        if (fill) begin
            tag_mem[sel_way][index] <= tag_in;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '{default: '0};
            dirty_q <= '{default: '0};
            lru_q   <= '0;
        end else begin
            // Line stays invalid until its last word is in
            if (fill) begin
                valid_q[sel_way][index] <= cmd.valid_in;
                dirty_q[sel_way][index] <= 1'b0;
            end
            if (store) begin
                dirty_q[sel_way][index] <= 1'b1;
            end
            if ((fill && cmd.valid_in) || touch) begin
                lru_q[index] <= ~sel_way;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/cache_control.sv
`timescale 1ns/100ps
`default_nettype none

module cache_control #(
    parameter int OFFSET_WIDTH = 3
) (
    input  cache_pkg::mgr_state_e   state,
    input  logic [OFFSET_WIDTH-1:0] counter,
    input  logic                    dc_read,
    input  logic                    dc_write,
    input  logic [OFFSET_WIDTH-1:0] ic_offset,
    input  logic [OFFSET_WIDTH-1:0] dc_offset,
    input  cache_pkg::set_status_t  ic_status,
    input  cache_pkg::set_status_t  dc_status,
    output cache_pkg::set_cmd_t     ic_cmd,
    output cache_pkg::set_cmd_t     dc_cmd,
    output logic [OFFSET_WIDTH-1:0] ic_word_sel,
    output logic [OFFSET_WIDTH-1:0] dc_word_sel,
    output logic                    ic_from_ram,
    output logic                    dc_from_ram,
    output cache_pkg::ram_sel_e     ram_sel,
    output logic                    ram_en,
    output logic                    ram_write,
    output cache_pkg::mgr_state_e   state_next,
    output logic [OFFSET_WIDTH-1:0] counter_next
);

    logic last_word;
    logic dc_access;
    logic ic_miss;
    logic dc_miss;

    assign last_word = &counter;
    assign dc_access = dc_read | dc_write;
    assign ic_miss   = ~ic_status.hit;
    assign dc_miss   = dc_access & ~dc_status.hit;

    always_comb begin
        // Idle values, both caches looked up at the CPU offsets
        ic_cmd       = '{enable: 1'b1, cmp: 1'b1, write: 1'b0, valid_in: 1'b0, byte_en: '0};
        dc_cmd       = '{enable: dc_access, cmp: 1'b1, write: 1'b0, valid_in: 1'b0,
                         byte_en: '0};
        ic_word_sel  = ic_offset;
        dc_word_sel  = dc_offset;
        ic_from_ram  = 1'b1;
        dc_from_ram  = 1'b0;
        ram_sel      = cache_pkg::IC_LINE;
        ram_en       = 1'b0;
        ram_write    = 1'b0;
        state_next   = state;
        counter_next = counter;

        unique case (state)
            //////////////////////////////
            cache_pkg::NORMAL: begin
                // Store hit, bytes are masked by the manager
                dc_cmd.write   = dc_write & dc_status.hit;
                dc_cmd.byte_en = '1;
                if (ic_miss && dc_miss) begin
                    state_next   = cache_pkg::DOUBLE_MISS;
                    counter_next = '0;
                end else if (ic_miss) begin
                    state_next   = cache_pkg::IC_MISS;
                    counter_next = '0;
                end else if (dc_miss) begin
                    state_next   = dc_status.dirty ? cache_pkg::DC_WRITEBACK
                                                   : cache_pkg::DC_MISS;
                    counter_next = '0;
                end
            end

            //////////////////////////////
            cache_pkg::IC_MISS, cache_pkg::DOUBLE_MISS: begin
                // Instruction line fill, one word per beat
                ic_cmd      = '{enable: 1'b1, cmp: 1'b0, write: 1'b1, valid_in: last_word,
                                byte_en: '1};
                ic_word_sel = counter;

                // Data cache is pointed at the instruction line
                dc_cmd      = '{enable: 1'b1, cmp: 1'b1, write: 1'b0, valid_in: 1'b0,
                                byte_en: '0};
                dc_word_sel = counter;

                if (dc_status.hit) begin
                    ic_from_ram = 1'b0;
                end else begin
                    ram_en  = 1'b1;
                    ram_sel = cache_pkg::IC_LINE;
                end

                counter_next = counter + 1'b1;
                if (last_word) begin
                    if (state == cache_pkg::IC_MISS) begin
                        state_next   = cache_pkg::NORMAL;
                        counter_next = counter;
                    end else begin
                        state_next = cache_pkg::DC_MISS;
                    end
                end
            end

            //////////////////////////////
            cache_pkg::DC_MISS: begin
                dc_cmd      = '{enable: 1'b1, cmp: 1'b0, write: 1'b0, valid_in: 1'b0,
                                byte_en: '0};
                dc_word_sel = counter;

                // After a double miss the victim is checked here first
                if (counter == '0 && dc_status.dirty) begin
                    state_next   = cache_pkg::DC_WRITEBACK;
                    counter_next = '0;
                end else begin
                    dc_cmd.write    = 1'b1;
                    dc_cmd.valid_in = last_word;
                    dc_cmd.byte_en  = '1;
                    dc_from_ram     = 1'b1;
                    ram_en          = 1'b1;
                    ram_sel         = cache_pkg::DC_LINE;
                    counter_next    = counter + 1'b1;
                    if (last_word) begin
                        state_next   = cache_pkg::NORMAL;
                        counter_next = counter;
                    end
                end
            end

            //////////////////////////////
            cache_pkg::DC_WRITEBACK: begin
                // Victim words out to RAM, last beat drops the line
                dc_cmd      = '{enable: 1'b1, cmp: 1'b0, write: last_word, valid_in: 1'b0,
                                byte_en: '0};
                dc_word_sel = counter;
                ram_en      = 1'b1;
                ram_write   = 1'b1;
                ram_sel     = cache_pkg::DC_VICTIM;

                counter_next = counter + 1'b1;
                if (last_word) begin
                    state_next = cache_pkg::DC_MISS;
                end
            end

            default: begin
                state_next   = cache_pkg::NORMAL;
                counter_next = '1;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: design/cache_manage_unit.sv
`timescale 1ns/100ps
`default_nettype none

module cache_manage_unit #(
    parameter int OFFSET_WIDTH = 3,
    parameter int INDEX_WIDTH  = 6
) (
    input  logic                  clk,
    input  logic                  rst,
    input  cache_pkg::word_addr_t ic_addr,
    input  cache_pkg::dc_req_t    dc_req,
    input  cache_pkg::word_t      ram_rdata,
    input  logic                  ram_ready,
    output cache_pkg::word_t      ic_data,
    output cache_pkg::word_t      dc_rdata,
    output logic                  mem_stall,
    output cache_pkg::ram_req_t   ram_req
);

    localparam int TAG_WIDTH = 30 - OFFSET_WIDTH - INDEX_WIDTH;

    typedef logic [TAG_WIDTH-1:0]    tag_t;
    typedef logic [INDEX_WIDTH-1:0]  index_t;
    typedef logic [OFFSET_WIDTH-1:0] offset_t;

    cache_pkg::mgr_state_e  state;
    cache_pkg::mgr_state_e  state_next;
    offset_t                counter;
    offset_t                counter_next;
    logic                   write_after_load;
    logic                   loading_ic;
    logic                   step;

    tag_t                   ic_tag;
    tag_t                   dc_tag;
    tag_t                   dc_tag_out;
    index_t                 ic_index;
    index_t                 dc_index;
    offset_t                ic_offset;
    offset_t                dc_offset;
    offset_t                ic_word_sel;
    offset_t                dc_word_sel;

    cache_pkg::set_cmd_t    ic_cmd;
    cache_pkg::set_cmd_t    dc_cmd;
    cache_pkg::set_cmd_t    ic_array_cmd;
    cache_pkg::set_cmd_t    dc_array_cmd;
    cache_pkg::set_status_t ic_status;
    cache_pkg::set_status_t dc_status;
    logic                   ic_from_ram;
    logic                   dc_from_ram;
    cache_pkg::word_t       ic_fill_data;
    cache_pkg::word_t       dc_wdata;

    cache_pkg::ram_sel_e    ram_sel;
    logic                   ram_en;
    logic                   ram_write;
    cache_pkg::word_addr_t  ram_addr;

    //////////////////////////////
    // Address split
    //////////////////////////////

    assign loading_ic = (state == cache_pkg::IC_MISS) || (state == cache_pkg::DOUBLE_MISS);

    assign ic_tag    = ic_addr[29 -: TAG_WIDTH];
    assign ic_index  = ic_addr[OFFSET_WIDTH +: INDEX_WIDTH];
    assign ic_offset = ic_addr[OFFSET_WIDTH-1:0];

    // Data cache looks at the instruction line during its refill
    assign dc_tag    = loading_ic ? ic_tag : dc_req.addr[29 -: TAG_WIDTH];
    assign dc_index  = loading_ic ? ic_index : dc_req.addr[OFFSET_WIDTH +: INDEX_WIDTH];
    assign dc_offset = dc_req.addr[OFFSET_WIDTH-1:0];

    //////////////////////////////
    // Control and state
    //////////////////////////////

    cache_control #(
        .OFFSET_WIDTH (OFFSET_WIDTH)
    ) cache_control_i (
        .state        (state),
        .counter      (counter),
        .dc_read      (dc_req.read),
        .dc_write     (dc_req.write),
        .ic_offset    (ic_offset),
        .dc_offset    (dc_offset),
        .ic_status    (ic_status),
        .dc_status    (dc_status),
        .ic_cmd       (ic_cmd),
        .dc_cmd       (dc_cmd),
        .ic_word_sel  (ic_word_sel),
        .dc_word_sel  (dc_word_sel),
        .ic_from_ram  (ic_from_ram),
        .dc_from_ram  (dc_from_ram),
        .ram_sel      (ram_sel),
        .ram_en       (ram_en),
        .ram_write    (ram_write),
        .state_next   (state_next),
        .counter_next (counter_next)
    );

    // Beats without a RAM access always complete
    assign step = ~ram_en | ram_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state            <= cache_pkg::NORMAL;
            counter          <= '1;
            write_after_load <= 1'b0;
        end else begin
            if (step) begin
                state   <= state_next;
                counter <= counter_next;
            end
            // A store held through a miss gets one more stalled cycle
            if (state == cache_pkg::NORMAL) begin
                write_after_load <= 1'b0;
            end else if (dc_req.write) begin
                write_after_load <= 1'b1;
            end
        end
    end

    // No stall reported while in reset
    assign mem_stall = ~rst & ((state != cache_pkg::NORMAL) ||
                               (state_next != cache_pkg::NORMAL) ||
                               write_after_load);

    //////////////////////////////
    // Data steering
    //////////////////////////////

    // Cache writes only land on a completing beat
    always_comb begin
        ic_array_cmd       = ic_cmd;
        ic_array_cmd.write = ic_cmd.write & step;
        dc_array_cmd       = dc_cmd;
        dc_array_cmd.write = dc_cmd.write & step;
        if (!dc_from_ram) begin
            dc_array_cmd.byte_en = dc_cmd.byte_en & dc_req.byte_en;
        end
    end

    assign ic_fill_data = ic_from_ram ? ram_rdata : dc_rdata;
    assign dc_wdata     = dc_from_ram ? ram_rdata : dc_req.wdata;

    cache_set_array #(
        .OFFSET_WIDTH (OFFSET_WIDTH),
        .INDEX_WIDTH  (INDEX_WIDTH)
    ) ic_array (
        .clk      (clk),
        .rst      (rst),
        .cmd      (ic_array_cmd),
        .index    (ic_index),
        .word_sel (ic_word_sel),
        .tag_in   (ic_tag),
        .wdata    (ic_fill_data),
        .status   (ic_status),
        .tag_out  (),
        .rdata    (ic_data)
    );

    cache_set_array #(
        .OFFSET_WIDTH (OFFSET_WIDTH),
        .INDEX_WIDTH  (INDEX_WIDTH)
    ) dc_array (
        .clk      (clk),
        .rst      (rst),
        .cmd      (dc_array_cmd),
        .index    (dc_index),
        .word_sel (dc_word_sel),
        .tag_in   (dc_tag),
        .wdata    (dc_wdata),
        .status   (dc_status),
        .tag_out  (dc_tag_out),
        .rdata    (dc_rdata)
    );

    //////////////////////////////
    // RAM request
    //////////////////////////////

    always_comb begin
        unique case (ram_sel)
            cache_pkg::DC_LINE:   ram_addr = {dc_tag, dc_index, counter};
            cache_pkg::DC_VICTIM: ram_addr = {dc_tag_out, dc_index, counter};
            default:              ram_addr = {ic_tag, ic_index, counter};
        endcase
    end

    // Write data is always the victim word under the counter
    assign ram_req = '{en: ram_en, write: ram_write, addr: ram_addr, wdata: dc_rdata};

endmodule

`default_nettype wire

// File: verif/ram_model.sv
`timescale 1ns/100ps
`default_nettype none

module ram_model (
    input  logic                clk,
    input  logic                rst,
    input  cache_pkg::ram_req_t req,
    output cache_pkg::word_t    rdata,
    output logic                ready
);

    localparam int WORDS = 1 << 16;

    cache_pkg::word_t mem [WORDS];
    logic [1:0]       wait_q;

    // Start contents, unique per word address
    function automatic cache_pkg::word_t init_word(input cache_pkg::word_addr_t a);
        return {2'b10, a} ^ 32'h5a5a_0000;
    endfunction

    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = init_word(cache_pkg::word_addr_t'(i));
        end
    end

    assign rdata = mem[req.addr[15:0]];

    // Each beat waits wait_q+1 cycles before ready
    always @(posedge clk) begin
        if (rst) begin
            ready  <= 1'b0;
            wait_q <= 2'd0;
        end else if (req.en) begin
            if (ready) begin
                if (req.write) begin
                    mem[req.addr[15:0]] <= req.wdata;
                end
                ready  <= 1'b0;
                wait_q <= 2'($urandom_range(3, 0));
            end else if (wait_q == 2'd0) begin
                ready <= 1'b1;
            end else begin
                wait_q <= wait_q - 2'd1;
            end
        end else begin
            ready <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: verif/cache_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module cache_assertions (
    input wire logic                  clk,
    input wire logic                  rst,
    input wire cache_pkg::mgr_state_e state,
    input wire logic                  mem_stall,
    input wire cache_pkg::ram_req_t   ram_req
);

    // RAM traffic only while the CPU is stalled
    a_ram_en_stall: assert property (
        @(posedge clk) disable iff (rst) ram_req.en |-> mem_stall
    ) else $error("RAM request without mem_stall");

    // Only the writeback state writes RAM
    a_write_in_wb: assert property (
        @(posedge clk) disable iff (rst)
        ram_req.write |-> (state == cache_pkg::DC_WRITEBACK)
    ) else $error("RAM write outside DC_WRITEBACK");

    a_reset_state: assert property (
        @(posedge clk) rst |=> (state == cache_pkg::NORMAL)
    ) else $error("state not NORMAL after reset");

endmodule

bind cache_manage_unit cache_assertions cache_assertions_i (
    .clk       (clk),
    .rst       (rst),
    .state     (state),
    .mem_stall (mem_stall),
    .ram_req   (ram_req)
);

`default_nettype wire

// File: verif/tb_cache.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cache;

    localparam int TOTAL_OPS = 16 + 16 + 24 + 1 + 16 + 400;

    logic                  clk = 1'b0;
    logic                  rst;
    cache_pkg::word_addr_t ic_addr;
    cache_pkg::dc_req_t    dc_req;
    cache_pkg::word_t      ram_rdata;
    logic                  ram_ready;
    cache_pkg::word_t      ic_data;
    cache_pkg::word_t      dc_rdata;
    logic                  mem_stall;
    cache_pkg::ram_req_t   ram_req;

    cache_pkg::word_t      shadow [1 << 16];
    int                    error_count = 0;

    always #20 clk = ~clk;

    cache_manage_unit #(
        .OFFSET_WIDTH (3),
        .INDEX_WIDTH  (6)
    ) cache_manage_unit_i (
        .clk       (clk),
        .rst       (rst),
        .ic_addr   (ic_addr),
        .dc_req    (dc_req),
        .ram_rdata (ram_rdata),
        .ram_ready (ram_ready),
        .ic_data   (ic_data),
        .dc_rdata  (dc_rdata),
        .mem_stall (mem_stall),
        .ram_req   (ram_req)
    );

    ram_model ram_model_i (
        .clk   (clk),
        .rst   (rst),
        .req   (ram_req),
        .rdata (ram_rdata),
        .ready (ram_ready)
    );

    //////////////////////////////
    // Reference and checking
    //////////////////////////////

    function automatic cache_pkg::word_t expected_word(input cache_pkg::word_addr_t a);
        return shadow[a[15:0]];
    endfunction

    task automatic check_value(input string name, input cache_pkg::word_t got,
                               input cache_pkg::word_t exp);
        if (got !== exp) begin
            error_count++;
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    endtask

    // Outputs are settled at the falling edge
    always @(negedge clk) begin
        if (!rst && !mem_stall) begin
            check_value("ic_data", ic_data, expected_word(ic_addr));
            if (dc_req.read) begin
                check_value("dc_rdata", dc_rdata, expected_word(dc_req.addr));
            end
            if (dc_req.write) begin
                for (int b = 0; b < 4; b++) begin
                    if (dc_req.byte_en[b]) begin
                        shadow[dc_req.addr[15:0]][8*b +: 8] = dc_req.wdata[8*b +: 8];
                    end
                end
            end
        end
    end

    initial begin
        repeat (10 + 200 * TOTAL_OPS) @(posedge clk);
        $display("Timeout: the cache did not finish the operations in time");
        $display("TEST RESULT: FAIL");
        $fatal(1);
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    // One CPU operation, held until mem_stall is low
    task automatic run_op(input cache_pkg::word_addr_t fetch_addr, input logic rd,
                          input logic wr, input cache_pkg::word_addr_t addr,
                          input cache_pkg::word_t data, input cache_pkg::byte_en_t be);
        ic_addr        = fetch_addr;
        dc_req.read    = rd;
        dc_req.write   = wr;
        dc_req.addr    = addr;
        dc_req.wdata   = data;
        dc_req.byte_en = be;
        @(negedge clk);
        while (mem_stall) begin
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        dc_req.read  = 1'b0;
        dc_req.write = 1'b0;
    endtask

    initial begin
        cache_pkg::word_addr_t a;
        cache_pkg::word_addr_t code;
        int                    kind;

        void'($urandom(32'h5ec7));
        for (int i = 0; i < (1 << 16); i++) begin
            shadow[i] = {2'b10, 30'(i)} ^ 32'h5a5a_0000;
        end
        code   = 30'h0100;
        rst    = 1'b1;
        ic_addr = code;
        dc_req = '0;
        repeat (10) @(posedge clk);
        #2;
        check_value("mem_stall", 32'(mem_stall), 32'h0);
        check_value("ram_req.en", 32'(ram_req.en), 32'h0);
        check_value("ram_req.write", 32'(ram_req.write), 32'h0);
        rst = 1'b0;

        // Cold fetches and loads
        for (int i = 0; i < 8; i++) begin
            run_op(code + 30'(i), 1'b0, 1'b0, '0, '0, '0);
            run_op(code, 1'b1, 1'b0, 30'h1800 + 30'(i), '0, '0);
        end

        // Byte-enabled stores, each loaded back
        for (int i = 0; i < 8; i++) begin
            a = 30'h2000 + 30'(3 * i);
            run_op(code, 1'b0, 1'b1, a, $urandom, 4'($urandom));
            run_op(code, 1'b1, 1'b0, a, '0, '0);
        end

        // Three tags on one index force dirty evictions
        for (int t = 0; t < 3; t++) begin
            for (int w = 0; w < 4; w++) begin
                run_op(code, 1'b0, 1'b1, 30'h2100 + 30'(512 * t + w), $urandom, 4'hf);
            end
        end
        for (int t = 0; t < 3; t++) begin
            for (int w = 0; w < 4; w++) begin
                run_op(code, 1'b1, 1'b0, 30'h2100 + 30'(512 * t + w), '0, '0);
            end
        end
        for (int t = 0; t < 3; t++) begin
            for (int w = 0; w < 4; w++) begin
                a = 30'h2100 + 30'(512 * t + w);
                check_value("ram_word", ram_model_i.mem[a[15:0]], expected_word(a));
            end
        end

        // Instruction and data miss in the same cycle
        run_op(30'h0140, 1'b1, 1'b0, 30'h2400, '0, '0);

        // Fetch of a line with newer data in the data cache
        for (int i = 0; i < 8; i++) begin
            run_op(code, 1'b0, 1'b1, 30'h3000 + 30'(i), $urandom, 4'hf);
        end
        for (int i = 0; i < 8; i++) begin
            run_op(30'h3000 + 30'(i), 1'b0, 1'b0, '0, '0, '0);
        end

        // Random mix over four conflicting lines
        for (int n = 0; n < 400; n++) begin
            kind = $urandom_range(2, 0);
            a    = 30'h2800 + 30'(512 * $urandom_range(3, 0)) + 30'($urandom_range(31, 0));
            if (kind == 0) begin
                run_op(code, 1'b1, 1'b0, a, '0, '0);
            end else if (kind == 1) begin
                run_op(code, 1'b0, 1'b1, a, $urandom, 4'($urandom));
            end else begin
                code = 30'h0200 + 30'($urandom_range(63, 0));
                run_op(code, 1'b0, 1'b0, '0, '0, '0);
            end
        end

        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
design/cache_pkg.sv
design/cache_set_array.sv
design/cache_control.sv
design/cache_manage_unit.sv
verif/ram_model.sv
verif/cache_assertions.sv
verif/tb_cache.sv

// File: Makefile
TOP = tb_cache

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): sources.f design/*.sv verif/*.sv
	verilator --binary --timing --assert -j 0 -f sources.f --top-module $(TOP) -Mdir obj_dir

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TEST RESULT: PASS"

lint:
	verilator --lint-only --timing -f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir
